/* logic/apu_pkg.sv */
package apu_pkg;

	localparam int ADDR_W = 5;
	localparam int DATA_W = 8;

	typedef enum logic [ADDR_W-1:0] {
		PULSE0_CTRL = 5'h00,
		PULSE0_TLO  = 5'h02,
		PULSE0_THI  = 5'h03,
		PULSE1_CTRL = 5'h04,
		PULSE1_TLO  = 5'h06,
		PULSE1_THI  = 5'h07,
		STATUS      = 5'h15,
		FRAME_CTRL  = 5'h17
	} apu_reg_e;

	// S1..S4 are steps 1 to 4, S0 is the fifth step.
	typedef enum logic [2:0] {S0, S1, S2, S3, S4} frame_state_e;

	localparam logic [11:0] FRAME_LEN [5] = '{
		12'd3727, 12'd3727, 12'd3728, 12'd3728, 12'd3725
	};

	localparam logic [7:0] LENGTH_TABLE [32] = '{
		8'd10,  8'd254, 8'd20,  8'd2,   8'd40,  8'd4,   8'd80,  8'd6,
		8'd160, 8'd8,   8'd60,  8'd10,  8'd14,  8'd12,  8'd26,  8'd14,
		8'd12,  8'd16,  8'd24,  8'd18,  8'd48,  8'd20,  8'd96,  8'd22,
		8'd192, 8'd24,  8'd72,  8'd26,  8'd16,  8'd28,  8'd32,  8'd30
	};

	// msb plays first.
	localparam logic [7:0] DUTY_TABLE [4] = '{
		8'b0100_0000, // 12.5 %.
		8'b0110_0000, // 25 %.
		8'b0111_1000, // 50 %.
		8'b1001_1111  // 75 %.
	};

	// pulse mix curve, scaled so a sum of 30 gives full range.
	localparam logic [7:0] MIX_TABLE [31] = '{
		8'd0,   8'd11,  8'd23,  8'd34,  8'd44,  8'd55,  8'd65,  8'd75,
		8'd85,  8'd94,  8'd104, 8'd113, 8'd122, 8'd130, 8'd139, 8'd147,
		8'd156, 8'd164, 8'd171, 8'd179, 8'd187, 8'd194, 8'd201, 8'd209,
		8'd216, 8'd222, 8'd229, 8'd236, 8'd242, 8'd249, 8'd255
	};

endpackage

/* logic/apu_regs.sv */
`timescale 1ns/1ps

module apu_regs (
	input  logic                        clk_sys,
	input  logic                        rst_sys_n,
	input  logic                        wb_cyc,
	input  logic                        wb_stb,
	input  logic                        wb_we,
	input  logic [apu_pkg::ADDR_W-1:0]  wb_adr,
	input  logic [apu_pkg::DATA_W-1:0]  wb_dat_w,
	output logic [apu_pkg::DATA_W-1:0]  wb_dat_r,
	output logic                        wb_ack,
	output logic [1:0]                  duty0,
	output logic                        halt0,
	output logic [3:0]                  volume0,
	output logic [10:0]                 period0,
	output logic                        length_load0,
	output logic [7:0]                  length_val0,
	output logic                        enable0,
	output logic [1:0]                  duty1,
	output logic                        halt1,
	output logic [3:0]                  volume1,
	output logic [10:0]                 period1,
	output logic                        length_load1,
	output logic [7:0]                  length_val1,
	output logic                        enable1,
	input  logic                        active0,
	input  logic                        active1,
	output logic                        frame_mode,
	output logic                        irq_inhibit,
	output logic                        frame_restart,
	input  logic                        frame_irq_req,
	output logic                        irq
);
	import apu_pkg::*;

	logic              req;
	logic              wr;
	logic              rd;
	logic              ch;
	apu_reg_e          reg_sel;
	logic [DATA_W-1:0] status;
	logic [1:0]        duty_r [2];
	logic [1:0]        halt_r;
	logic [3:0]        volume_r [2];
	logic [10:0]       period_r [2];
	logic [7:0]        length_val_r [2];
	logic [1:0]        length_load_r;
	logic [1:0]        enable_r;

	assign req = wb_cyc && wb_stb && !wb_ack; // one ack per strobe.
	assign wr = req && wb_we;
	assign rd = req && !wb_we;
	assign ch = wb_adr[2]; // pulse 1 sits 4 above pulse 0.
	assign reg_sel = apu_reg_e'(wb_adr);
	assign status = {1'b0, irq, 4'b0000, active1, active0};

	always_ff @(posedge clk_sys, negedge rst_sys_n) begin
		if (!rst_sys_n)
			wb_ack <= 1'b0;
		else
			wb_ack <= req;
	end

	always_ff @(posedge clk_sys, negedge rst_sys_n) begin
		if (!rst_sys_n) begin
			length_load_r <= 2'b00;
			enable_r <= 2'b00;
			frame_mode <= 1'b0;
			irq_inhibit <= 1'b0;
			frame_restart <= 1'b0;
		end else begin
			length_load_r <= 2'b00;
			frame_restart <= 1'b0;
			if (wr) begin
				case (reg_sel)
				PULSE0_THI, PULSE1_THI: length_load_r[ch] <= enable_r[ch];
				STATUS: enable_r <= wb_dat_w[1:0];
				FRAME_CTRL: begin
					frame_mode <= wb_dat_w[7];
					irq_inhibit <= wb_dat_w[6];
					frame_restart <= 1'b1;
				end
				default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr) begin
			case (reg_sel)
			PULSE0_CTRL, PULSE1_CTRL: begin
				duty_r[ch] <= wb_dat_w[7:6];
				halt_r[ch] <= wb_dat_w[5];
				volume_r[ch] <= wb_dat_w[3:0];
			end
			PULSE0_TLO, PULSE1_TLO: period_r[ch][7:0] <= wb_dat_w;
			PULSE0_THI, PULSE1_THI: begin
				period_r[ch][10:8] <= wb_dat_w[2:0];
				length_val_r[ch] <= LENGTH_TABLE[wb_dat_w[7:3]];
			end
			default: ;
			endcase
		end
		if (rd)
			wb_dat_r <= (reg_sel == STATUS) ? status : '0;
	end

	// frame interrupt flag.
	always_ff @(posedge clk_sys, negedge rst_sys_n) begin
		if (!rst_sys_n)
			irq <= 1'b0;
		else if (frame_irq_req && !irq_inhibit)
			irq <= 1'b1;
		else if (irq_inhibit || (rd && reg_sel == STATUS))
			irq <= 1'b0;
	end

	assign duty0 = duty_r[0];
	assign halt0 = halt_r[0];
	assign volume0 = volume_r[0];
	assign period0 = period_r[0];
	assign length_load0 = length_load_r[0];
	assign length_val0 = length_val_r[0];
	assign enable0 = enable_r[0];

	assign duty1 = duty_r[1];
	assign halt1 = halt_r[1];
	assign volume1 = volume_r[1];
	assign period1 = period_r[1];
	assign length_load1 = length_load_r[1];
	assign length_val1 = length_val_r[1];
	assign enable1 = enable_r[1];

endmodule

/* logic/apu_frame_seq.sv */
`timescale 1ns/1ps

module apu_frame_seq (
	input  logic clk_sys,
	input  logic rst_sys_n,
	input  logic frame_mode,
	input  logic frame_restart,
	output logic apu_tick,
	output logic quarter_tick,
	output logic half_tick,
	output logic frame_irq_req
);
	import apu_pkg::*;

	frame_state_e state;
	logic [11:0]  frame_cnt;
	logic         restart_pend;

	// apu rate is half of clk_sys.
	always_ff @(posedge clk_sys, negedge rst_sys_n) begin
		if (!rst_sys_n)
			apu_tick <= 1'b0;
		else
			apu_tick <= ~apu_tick;
	end

	// restart waits for the next apu tick.
	always_ff @(posedge clk_sys, negedge rst_sys_n) begin
		if (!rst_sys_n)
			restart_pend <= 1'b0;
		else
			restart_pend <= frame_restart || (restart_pend && !apu_tick);
	end

	always_ff @(posedge clk_sys, negedge rst_sys_n) begin
		if (!rst_sys_n) begin
			state <= S1;
			frame_cnt <= FRAME_LEN[0];
			quarter_tick <= 1'b0;
			half_tick <= 1'b0;
			frame_irq_req <= 1'b0;
		end else begin
			quarter_tick <= 1'b0;
			half_tick <= 1'b0;
			frame_irq_req <= 1'b0;
			if (apu_tick) begin
				if (restart_pend) begin
					state <= S1;
					frame_cnt <= FRAME_LEN[0];
				end else if (frame_cnt != 12'd0) begin
					frame_cnt <= frame_cnt - 12'd1;
				end else begin
					case (state)
					S1: begin
						state <= S2;
						frame_cnt <= FRAME_LEN[1];
						quarter_tick <= 1'b1;
					end
					S2: begin
						state <= S3;
						frame_cnt <= FRAME_LEN[2];
						quarter_tick <= 1'b1;
						half_tick <= 1'b1;
					end
					S3: begin
						state <= S4;
						frame_cnt <= FRAME_LEN[3];
						quarter_tick <= 1'b1;
					end
					S4: begin
						if (frame_mode) begin // 5-step, silent here.
							state <= S0;
							frame_cnt <= FRAME_LEN[4];
						end else begin
							state <= S1;
							frame_cnt <= FRAME_LEN[0];
							quarter_tick <= 1'b1;
							half_tick <= 1'b1;
							frame_irq_req <= 1'b1;
						end
					end
					S0: begin
						state <= S1;
						frame_cnt <= FRAME_LEN[0];
						quarter_tick <= 1'b1;
						half_tick <= 1'b1;
					end
					default: begin
						state <= S1;
						frame_cnt <= FRAME_LEN[0];
					end
					endcase
				end
			end
		end
	end

endmodule

/* logic/apu_pulse.sv */
`timescale 1ns/1ps

module apu_pulse (
	input  logic        clk_sys,
	input  logic        rst_sys_n,
	input  logic        apu_tick,
	input  logic        half_tick,
	input  logic        enable,
	input  logic [1:0]  duty,
	input  logic        halt,
	input  logic [3:0]  volume,
	input  logic [10:0] period,
	input  logic        length_load,
	input  logic [7:0]  length_val,
	output logic [3:0]  level,
	output logic        active
);
	import apu_pkg::*;

	logic [10:0] timer;
	logic [2:0]  seq_step;
	logic [7:0]  length_cnt;
	logic [7:0]  pattern;
	logic        duty_bit;
	logic        audible;

	// period timer and duty sequencer.
	always_ff @(posedge clk_sys, negedge rst_sys_n) begin
		if (!rst_sys_n) begin
			timer <= 11'd0;
			seq_step <= 3'd0;
		end else if (apu_tick) begin
			if (timer == 11'd0) begin
				timer <= period;
				seq_step <= seq_step + 3'd1;
			end else begin
				timer <= timer - 11'd1;
			end
		end
	end

	always_ff @(posedge clk_sys, negedge rst_sys_n) begin
		if (!rst_sys_n)
			length_cnt <= 8'd0;
		else if (!enable)
			length_cnt <= 8'd0;
		else if (length_load)
			length_cnt <= length_val;
		else if (half_tick && !halt && length_cnt != 8'd0)
			length_cnt <= length_cnt - 8'd1;
	end

	assign pattern = DUTY_TABLE[duty];
	assign duty_bit = pattern[~seq_step]; // step 0 reads bit 7.
	assign active = (length_cnt != 8'd0);

	// short periods would alias, mute them.
	assign audible = duty_bit && active && (period >= 11'd8);
	assign level = audible ? volume : 4'd0;

endmodule

/* logic/apu_mixer.sv */
`timescale 1ns/1ps

module apu_mixer (
	input  logic                       clk_sys,
	input  logic                       rst_sys_n,
	input  logic [3:0]                 level0,
	input  logic [3:0]                 level1,
	output logic [apu_pkg::DATA_W-1:0] sample
);
	import apu_pkg::*;

	logic [4:0] level_sum;

	assign level_sum = {1'b0, level0} + {1'b0, level1}; // 0 to 30.

	always_ff @(posedge clk_sys, negedge rst_sys_n) begin
		if (!rst_sys_n)
			sample <= '0;
		else
			sample <= MIX_TABLE[level_sum];
	end

endmodule

/* logic/apu_top.sv */
`timescale 1ns/1ps

module apu_top (
	input  logic                       clk_sys,
	input  logic                       rst_sys_n,
	input  logic                       wb_cyc,
	input  logic                       wb_stb,
	input  logic                       wb_we,
	input  logic [apu_pkg::ADDR_W-1:0] wb_adr,
	input  logic [apu_pkg::DATA_W-1:0] wb_dat_w,
	output logic [apu_pkg::DATA_W-1:0] wb_dat_r,
	output logic                       wb_ack,
	output logic                       irq,
	output logic [apu_pkg::DATA_W-1:0] sample
);
	import apu_pkg::*;

	logic [1:0]  duty0;
	logic [1:0]  duty1;
	logic        halt0;
	logic        halt1;
	logic [3:0]  volume0;
	logic [3:0]  volume1;
	logic [10:0] period0;
	logic [10:0] period1;
	logic        length_load0;
	logic        length_load1;
	logic [7:0]  length_val0;
	logic [7:0]  length_val1;
	logic        enable0;
	logic        enable1;
	logic        active0;
	logic        active1;
	logic [3:0]  level0;
	logic [3:0]  level1;
	logic        frame_mode;
	logic        irq_inhibit;
	logic        frame_restart;
	logic        frame_irq_req;
	logic        apu_tick;
	logic        half_tick;

	apu_regs i_apu_regs (
		.clk_sys       (clk_sys),
		.rst_sys_n     (rst_sys_n),
		.wb_cyc        (wb_cyc),
		.wb_stb        (wb_stb),
		.wb_we         (wb_we),
		.wb_adr        (wb_adr),
		.wb_dat_w      (wb_dat_w),
		.wb_dat_r      (wb_dat_r),
		.wb_ack        (wb_ack),
		.duty0         (duty0),
		.halt0         (halt0),
		.volume0       (volume0),
		.period0       (period0),
		.length_load0  (length_load0),
		.length_val0   (length_val0),
		.enable0       (enable0),
		.duty1         (duty1),
		.halt1         (halt1),
		.volume1       (volume1),
		.period1       (period1),
		.length_load1  (length_load1),
		.length_val1   (length_val1),
		.enable1       (enable1),
		.active0       (active0),
		.active1       (active1),
		.frame_mode    (frame_mode),
		.irq_inhibit   (irq_inhibit),
		.frame_restart (frame_restart),
		.frame_irq_req (frame_irq_req),
		.irq           (irq)
	);

	// quarter ticks wait for an envelope unit.
	apu_frame_seq i_apu_frame_seq (
		.clk_sys       (clk_sys),
		.rst_sys_n     (rst_sys_n),
		.frame_mode    (frame_mode),
		.frame_restart (frame_restart),
		.apu_tick      (apu_tick),
		.quarter_tick  (),
		.half_tick     (half_tick),
		.frame_irq_req (frame_irq_req)
	);

	apu_pulse i_apu_pulse0 (
		.clk_sys     (clk_sys),
		.rst_sys_n   (rst_sys_n),
		.apu_tick    (apu_tick),
		.half_tick   (half_tick),
		.enable      (enable0),
		.duty        (duty0),
		.halt        (halt0),
		.volume      (volume0),
		.period      (period0),
		.length_load (length_load0),
		.length_val  (length_val0),
		.level       (level0),
		.active      (active0)
	);

	apu_pulse i_apu_pulse1 (
		.clk_sys     (clk_sys),
		.rst_sys_n   (rst_sys_n),
		.apu_tick    (apu_tick),
		.half_tick   (half_tick),
		.enable      (enable1),
		.duty        (duty1),
		.halt        (halt1),
		.volume      (volume1),
		.period      (period1),
		.length_load (length_load1),
		.length_val  (length_val1),
		.level       (level1),
		.active      (active1)
	);

	apu_mixer i_apu_mixer (
		.clk_sys   (clk_sys),
		.rst_sys_n (rst_sys_n),
		.level0    (level0),
		.level1    (level1),
		.sample    (sample)
	);

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic clk_sys,
	output logic rst_sys_n
);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys; // 8 ns period.
	end

	initial begin
		rst_sys_n = 1'b0;
		repeat (10) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_sys_n = 1'b1;
	end

endmodule

/* tb/apu_tb.sv */
`timescale 1ns/1ps

module apu_tb;
	import apu_pkg::*;

	// three 4-step and two 5-step frames, plus short pulse tests.
	localparam int TIMEOUT_CYCLES = 200_000;

	logic              clk_sys;
	logic              rst_sys_n;
	logic              wb_cyc;
	logic              wb_stb;
	logic              wb_we;
	logic [ADDR_W-1:0] wb_adr;
	logic [DATA_W-1:0] wb_dat_w;
	logic [DATA_W-1:0] wb_dat_r;
	logic              wb_ack;
	logic              irq;
	logic [DATA_W-1:0] sample;

	event  check_ev;
	string name_q[$];
	int    lo_q[$];
	int    hi_q[$];
	int    act_q[$];
	int    checks_posted = 0;
	int    checks_done = 0;
	int    cycle = 0;
	int    ack_cycle = 0;

	tb_clock i_tb_clock (
		.clk_sys   (clk_sys),
		.rst_sys_n (rst_sys_n)
	);

	apu_top i_apu_top (
		.clk_sys   (clk_sys),
		.rst_sys_n (rst_sys_n),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.irq       (irq),
		.sample    (sample)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "run stopped");
	endtask

	function automatic int mix_ref(input int level_sum);
		return int'(MIX_TABLE[level_sum]);
	endfunction

	function automatic int length_ref(input int index);
		return int'(LENGTH_TABLE[index]);
	endfunction

	// clk_sys cycles from a frame start to the end of the given step.
	function automatic int irq_time_ref(input int steps);
		int total;
		total = 0;
		for (int i = 0; i < steps; i++)
			total += (int'(FRAME_LEN[i]) + 1) * 2;
		return total;
	endfunction

	function automatic string format_mismatch(input string name, input int lo, input int hi,
			input int act);
		if (lo == hi)
			return $sformatf("MISMATCH %s expected %0d actual %0d", name, lo, act);
		return $sformatf("MISMATCH %s expected %0d..%0d actual %0d", name, lo, hi, act);
	endfunction

	task automatic post_check(input string name, input int lo, input int hi, input int act);
		name_q.push_back(name);
		lo_q.push_back(lo);
		hi_q.push_back(hi);
		act_q.push_back(act);
		checks_posted++;
		-> check_ev;
	endtask

	task automatic post_eq(input string name, input int exp, input int act);
		post_check(name, exp, exp, act);
	endtask

	task automatic bus_cycle(input logic we, input logic [ADDR_W-1:0] adr,
			input logic [DATA_W-1:0] dat, output logic [DATA_W-1:0] rdat);
		int waited;
		@(negedge clk_sys);
		assert (!wb_ack) else
			abort_run($sformatf("wishbone ack high before the strobe, address 0x%02h", adr));
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = dat;
		waited = 0;
		do begin
			@(negedge clk_sys);
			waited++;
		end while (!wb_ack && waited < 8);
		assert (wb_ack && waited == 1) else
			abort_run($sformatf("wishbone ack not one cycle after strobe, address 0x%02h", adr));
		rdat = wb_dat_r;
		ack_cycle = cycle;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat);
		logic [DATA_W-1:0] discard;
		bus_cycle(1'b1, adr, dat, discard);
	endtask

	task automatic wb_read(input logic [ADDR_W-1:0] adr, output logic [DATA_W-1:0] rdat);
		bus_cycle(1'b0, adr, '0, rdat);
	endtask

	// starts on a negedge, returns on the negedge after the next change.
	task automatic measure_phase(output int value, output int len);
		logic [DATA_W-1:0] start;
		start = sample;
		len = 0;
		while (sample == start) begin
			@(negedge clk_sys);
			len++;
		end
		value = int'(start);
	endtask

	task automatic watch_irq(input int cycles, output int seen);
		seen = 0;
		repeat (cycles) begin
			@(negedge clk_sys);
			if (irq)
				seen = 1;
		end
	endtask

	always @(posedge clk_sys) begin
		cycle <= cycle + 1;
		assert (cycle < TIMEOUT_CYCLES) else
			abort_run("timeout, the tests did not finish within the cycle limit");
	end

	initial begin : compare
		string name;
		int    lo;
		int    hi;
		int    act;
		forever begin
			@(check_ev);
			while (act_q.size() != 0) begin
				name = name_q.pop_front();
				lo = lo_q.pop_front();
				hi = hi_q.pop_front();
				act = act_q.pop_front();
				checks_done++;
				assert (act >= lo && act <= hi) else
					abort_run(format_mismatch(name, lo, hi, act));
			end
		end
	end

	initial begin : stimulus
		logic [DATA_W-1:0] rdat;
		int vol0;
		int vol1;
		int duty0;
		int per0;
		int val_a;
		int len_a;
		int val_b;
		int len_b;
		int peak;
		int t0;
		int seen;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		void'($urandom(32'h92c7_91ea));
		wait (rst_sys_n === 1'b1);

		post_eq("irq_after_reset", 0, int'(irq));
		post_eq("sample_after_reset", 0, int'(sample));
		wb_read(STATUS, rdat);
		post_eq("status_after_reset", 0, int'(rdat));
		wb_read(5'h1f, rdat);
		post_eq("unmapped_read", 0, int'(rdat));

		vol0 = $urandom_range(15, 1);
		per0 = $urandom_range(40, 8);
		wb_write(PULSE0_CTRL, {2'b10, 1'b1, 1'b0, vol0[3:0]}); // 50 %, halted.
		wb_write(PULSE0_TLO, per0[7:0]);
		wb_write(STATUS, 8'h01);
		wb_write(PULSE0_THI, {5'd1, per0[10:8]});
		measure_phase(val_a, len_a); // partial phases while the timer settles.
		measure_phase(val_a, len_a);
		measure_phase(val_a, len_a);
		measure_phase(val_b, len_b);
		post_eq("pulse_phase_a", 8 * (per0 + 1), len_a);
		post_eq("pulse_phase_b", 8 * (per0 + 1), len_b);
		post_eq("pulse_low", mix_ref(0), (val_a < val_b) ? val_a : val_b);
		post_eq("pulse_high", mix_ref(vol0), (val_a > val_b) ? val_a : val_b);

		// 75 % on one side always overlaps the other at equal periods.
		vol0 = $urandom_range(15, 1);
		vol1 = $urandom_range(15, 1);
		duty0 = $urandom_range(3, 2);
		wb_write(PULSE0_CTRL, {duty0[1:0], 1'b1, 1'b0, vol0[3:0]});
		wb_write(PULSE1_CTRL, {2'b11, 1'b1, 1'b0, vol1[3:0]});
		wb_write(PULSE1_TLO, per0[7:0]);
		wb_write(STATUS, 8'h03);
		wb_write(PULSE1_THI, {5'd1, per0[10:8]});
		peak = 0;
		repeat (48 * (per0 + 1) + 32) begin
			@(negedge clk_sys);
			if (int'(sample) > peak)
				peak = int'(sample);
		end
		post_eq("mix_peak", mix_ref(vol0 + vol1), peak);

		wb_write(STATUS, 8'h01);
		wb_write(PULSE0_CTRL, {2'b10, 1'b0, 1'b0, vol0[3:0]});
		wb_write(FRAME_CTRL, 8'h40); // restart inhibited, drops any old flag.
		wb_write(FRAME_CTRL, 8'h00);
		t0 = ack_cycle;
		wb_write(PULSE0_THI, {5'd3, per0[10:8]});
		wb_read(STATUS, rdat);
		post_eq("status_length_loaded", (length_ref(3) > 0) ? 1 : 0, int'(rdat));
		// end of step 3 lies between the two half ticks.
		while (cycle - t0 < irq_time_ref(3))
			@(negedge clk_sys);
		wb_read(STATUS, rdat);
		post_eq("status_one_half_tick", (length_ref(3) > 1) ? 1 : 0, int'(rdat));
		while (!irq)
			@(negedge clk_sys);
		// restart waits for an apu tick, so one cycle of slack.
		post_check("irq_time", irq_time_ref(4) + 3, irq_time_ref(4) + 4, cycle - t0);
		wb_read(STATUS, rdat);
		post_eq("status_frame_irq", 64 + ((length_ref(3) > 2) ? 1 : 0), int'(rdat));
		post_eq("irq_cleared_by_read", 0, int'(irq));

		wb_write(PULSE0_THI, {5'd3, per0[10:8]});
		wb_read(STATUS, rdat);
		post_eq("status_reloaded", 1, int'(rdat));
		wb_write(STATUS, 8'h00);
		wb_read(STATUS, rdat);
		post_eq("status_disabled", 0, int'(rdat));

		wb_write(FRAME_CTRL, 8'h40);
		watch_irq(2 * irq_time_ref(4) + 16, seen);
		post_eq("irq_inhibited", 0, seen);
		wb_read(STATUS, rdat);
		post_eq("status_inhibited", 0, int'(rdat));
		wb_write(FRAME_CTRL, 8'h80);
		watch_irq(2 * irq_time_ref(5) + 16, seen);
		post_eq("irq_five_step", 0, seen);
		wb_read(STATUS, rdat);
		post_eq("status_five_step", 0, int'(rdat));

		@(negedge clk_sys);
		if (checks_done == checks_posted) begin
			$display("Everything OK");
			$finish;
		end else begin
			abort_run("some posted checks were never compared");
		end
	end

endmodule

/* flist.f */
logic/apu_pkg.sv
logic/apu_regs.sv
logic/apu_frame_seq.sv
logic/apu_pulse.sv
logic/apu_mixer.sv
logic/apu_top.sv
tb/tb_clock.sv
tb/apu_tb.sv

/* Makefile */
OBJ = obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module apu_tb -Mdir $(OBJ) -f flist.f

run: compile
	./$(OBJ)/Vapu_tb

clean:
	rm -rf $(OBJ)
